// ==== design/tcm_dec_pkg.sv ====
// 4D-8PSK TCM decoder front end, shared definitions
// sample and metric widths, the 1/sqrt(2) scale constant and the
// metric, sign and hard point types used along the pipeline

`default_nettype none

package tcm_dec_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------

  // signed I/Q sample width
  localparam int DAT_W    = 8;
  // folded metric width, never wider than the samples
  localparam int SYMB_M_W = 8;

  //--------------------------------------------------------------------------
  // diagonal metric scale, 1/sqrt(2) ~= 181/256
  //--------------------------------------------------------------------------

  localparam int SCALE_FACTOR = 181;
  localparam int DIV_FACTOR_W = 8;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  // C0..C3, unsigned folded correlation metrics
  typedef logic [3:0][SYMB_M_W-1:0] symb_m_t;

  // per metric sign, set selects the opposite point C(k+4)
  typedef logic [3:0] symb_m_sign_t;

  // 8PSK point index 0..7
  typedef logic [2:0] hard_pnt_t;

  // hard points of the four 8PSK symbols inside one 4D symbol
  typedef hard_pnt_t [3:0] hard_4d_t;

endpackage

`default_nettype wire

// ==== design/tcm_dec_symb_mc.sv ====
// 8PSK symbol metric calculator
// folds each I/Q sample onto four correlation metrics C0..C3 with a sign
// per metric, then a non-linear quantizer step adds one lsb to the largest
// metric. strobe and framing come out four enabled cycles after the input

`default_nettype none

module tcm_dec_symb_mc #(
  parameter int pDAT_W    = tcm_dec_pkg::DAT_W,
  parameter int pSYMB_M_W = tcm_dec_pkg::SYMB_M_W
) (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  // 8PSK symbol input
  input  logic                      i1sps,
  input  logic                      isop,
  input  logic                      ival,
  input  logic                      ieop,
  input  logic signed [pDAT_W-1:0]  idat_re,
  input  logic signed [pDAT_W-1:0]  idat_im,
  // metric output
  output logic                      o1sps,
  output logic                      osop,
  output logic                      oval,
  output logic                      oeop,
  output tcm_dec_pkg::symb_m_t      osymb_m,
  output tcm_dec_pkg::symb_m_sign_t osymb_m_sign
);

  import tcm_dec_pkg::*;

  // extra bit for im+re / im-re and for abs of the most negative sample
  localparam int cDAT_W  = pDAT_W + 1;
  localparam int cMULT_W = cDAT_W + DIV_FACTOR_W;

  //--------------------------------------------------------------------------
  // strobe and framing delay line
  //--------------------------------------------------------------------------

  logic [3:0] sps_dly;
  logic [3:0] val_dly;
  logic [2:0] sop_dly;
  logic [2:0] eop_dly;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sps_dly <= '0;
      val_dly <= '0;
    end else if (iclkena) begin
      sps_dly <= {sps_dly[2:0], i1sps};
      val_dly <= {val_dly[2:0], ival};
    end
  end

  // framing is payload, only looked at with the strobe
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      sop_dly <= {sop_dly[1:0], isop};
      eop_dly <= {eop_dly[1:0], ieop};
    end
  end

  //--------------------------------------------------------------------------
  // stage 1 : sample latch, axis and diagonal projections
  //
  // C0 = |re|               opposite C4
  // C1 = |im + re|/sqrt(2)  opposite C5
  // C2 = |im|               opposite C6
  // C3 = |im - re|/sqrt(2)  opposite C7
  //--------------------------------------------------------------------------

  logic signed [pDAT_W-1:0] dat_re;
  logic signed [pDAT_W-1:0] dat_im;
  logic signed [cDAT_W-1:0] dat_sum;
  logic signed [cDAT_W-1:0] dat_dif;

  always_ff @(posedge iclk) begin
    if (iclkena && i1sps) begin
      dat_re  <= idat_re;
      dat_im  <= idat_im;
      // sign extended into the extra bit
      dat_sum <= idat_im + idat_re;
      dat_dif <= idat_im - idat_re;
    end
  end

  logic sign_re;
  logic sign_im;
  logic sign_sum;
  logic sign_dif;

  assign sign_re  = dat_re[pDAT_W-1];
  assign sign_im  = dat_im[pDAT_W-1];
  assign sign_sum = dat_sum[cDAT_W-1];
  assign sign_dif = dat_dif[cDAT_W-1];

  //--------------------------------------------------------------------------
  // stage 2 : abs values, signs ordered by metric index
  //--------------------------------------------------------------------------

  logic [pDAT_W-1:0] abs_re;
  logic [pDAT_W-1:0] abs_im;
  logic [cDAT_W-1:0] abs_sum;
  logic [cDAT_W-1:0] abs_dif;
  logic [3:0]        sign_s2;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // two's complement negate, -2^(n-1) maps to 2^(n-1) unsigned
      abs_re  <= (dat_re ^ {pDAT_W{sign_re}}) + sign_re;
      abs_im  <= (dat_im ^ {pDAT_W{sign_im}}) + sign_im;
      abs_sum <= (dat_sum ^ {cDAT_W{sign_sum}}) + sign_sum;
      abs_dif <= (dat_dif ^ {cDAT_W{sign_dif}}) + sign_dif;
      sign_s2 <= {sign_dif, sign_im, sign_sum, sign_re};
    end
  end

  //--------------------------------------------------------------------------
  // stage 3 : diagonal scaling by 181/256
  //--------------------------------------------------------------------------

  logic [pDAT_W-1:0]  abs_re_s3;
  logic [pDAT_W-1:0]  abs_im_s3;
  logic [cMULT_W-1:0] mult_sum;
  logic [cMULT_W-1:0] mult_dif;
  logic [3:0]         sign_s3;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      abs_re_s3 <= abs_re;
      abs_im_s3 <= abs_im;
      mult_sum  <= abs_sum * cMULT_W'(SCALE_FACTOR);
      mult_dif  <= abs_dif * cMULT_W'(SCALE_FACTOR);
      sign_s3   <= sign_s2;
    end
  end

  //--------------------------------------------------------------------------
  // non-linear quantizer : two layer max detect
  //--------------------------------------------------------------------------

  logic [pDAT_W-1:0] met [4];
  logic [pDAT_W-1:0] axis_m;
  logic [pDAT_W-1:0] diag_m;
  logic [1:0]        axis_idx;
  logic [1:0]        diag_idx;
  logic [1:0]        max_idx;

  always_comb begin
    met[0] = abs_re_s3;
    // 2*181/256 < 2, scaled diagonals fit pDAT_W bits
    met[1] = pDAT_W'(mult_sum >> DIV_FACTOR_W);
    met[2] = abs_im_s3;
    met[3] = pDAT_W'(mult_dif >> DIV_FACTOR_W);
    // layer 1, a tie goes to im
    if (met[0] > met[2]) begin
      axis_m   = met[0];
      axis_idx = 2'd0;
    end else begin
      axis_m   = met[2];
      axis_idx = 2'd2;
    end
    // a tie goes to the difference
    if (met[1] > met[3]) begin
      diag_m   = met[1];
      diag_idx = 2'd1;
    end else begin
      diag_m   = met[3];
      diag_idx = 2'd3;
    end
    // layer 2, a tie goes to the diagonal pair
    max_idx = (axis_m > diag_m) ? axis_idx : diag_idx;
  end

  //--------------------------------------------------------------------------
  // output register, loaded once per symbol
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && sps_dly[2]) begin
      osop         <= sop_dly[2];
      oeop         <= eop_dly[2];
      osymb_m_sign <= sign_s3;
      // top bits plus the winner lsb, no overflow possible
      for (int k = 0; k < 4; k++) begin
        osymb_m[k] <= met[k][pDAT_W-1 -: pSYMB_M_W] + pSYMB_M_W'(max_idx == k);
      end
    end
  end

  assign o1sps = sps_dly[3];
  assign oval  = val_dly[3];

endmodule

`default_nettype wire

// ==== design/tcm_dec_hard_dec.sv ====
// 8PSK hard decision
// finds the winning metric again and turns its index and sign into an
// 8PSK point, registered together with the metrics and the framing

`default_nettype none

module tcm_dec_hard_dec (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      i1sps,
  input  logic                      isop,
  input  logic                      ival,
  input  logic                      ieop,
  input  tcm_dec_pkg::symb_m_t      isymb_m,
  input  tcm_dec_pkg::symb_m_sign_t isymb_m_sign,
  output logic                      o1sps,
  output logic                      osop,
  output logic                      oval,
  output logic                      oeop,
  output tcm_dec_pkg::symb_m_t      osymb_m,
  output tcm_dec_pkg::symb_m_sign_t osymb_m_sign,
  output tcm_dec_pkg::hard_pnt_t    opnt
);

  import tcm_dec_pkg::*;

  logic [SYMB_M_W-1:0] max_m;
  logic [1:0]          max_idx;
  hard_pnt_t           pnt;

  //--------------------------------------------------------------------------
  // max detect, the quantizer lsb makes the winner a strict maximum
  //--------------------------------------------------------------------------

  always_comb begin
    max_m   = isymb_m[0];
    max_idx = 2'd0;
    for (int k = 1; k < 4; k++) begin
      if (isymb_m[k] > max_m) begin
        max_m   = isymb_m[k];
        max_idx = 2'(k);
      end
    end
    // sign set moves to the opposite point, +4
    pnt = {isymb_m_sign[max_idx], max_idx};
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      o1sps <= 1'b0;
      oval  <= 1'b0;
    end else if (iclkena) begin
      o1sps <= i1sps;
      oval  <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      osop         <= isop;
      oeop         <= ieop;
      osymb_m      <= isymb_m;
      osymb_m_sign <= isymb_m_sign;
      opnt         <= pnt;
    end
  end

endmodule

`default_nettype wire

// ==== design/tcm_dec_4d_pack.sv ====
// 4D symbol packer
// collects four consecutive 8PSK symbols, starting at a val symbol, into
// one 4D word of metrics, signs and hard points. sop/eop are taken from
// the val symbol, o4d_val pulses one enabled cycle after slot 3 fills

`default_nettype none

module tcm_dec_4d_pack (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  logic                            i1sps,
  input  logic                            isop,
  input  logic                            ival,
  input  logic                            ieop,
  input  tcm_dec_pkg::symb_m_t            isymb_m,
  input  tcm_dec_pkg::symb_m_sign_t       isymb_m_sign,
  input  tcm_dec_pkg::hard_pnt_t          ipnt,
  output logic                            o4d_val,
  output logic                            o4d_sop,
  output logic                            o4d_eop,
  output tcm_dec_pkg::hard_4d_t           o4d_pnt,
  output tcm_dec_pkg::symb_m_t      [3:0] o4d_symb_m,
  output tcm_dec_pkg::symb_m_sign_t [3:0] o4d_symb_m_sign
);

  //--------------------------------------------------------------------------
  // symbol counter
  //--------------------------------------------------------------------------

  logic [1:0] cnt;
  // inside a group that began with val
  logic       act;
  logic [1:0] slot;
  logic       take;

  // val always restarts at slot 0, also in the middle of a group
  assign slot = ival ? 2'd0 : cnt;
  // symbols outside a group are dropped
  assign take = i1sps && (ival || act);

  // strobes hold with iclkena low, consumers qualify them with iclkena
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt     <= '0;
      act     <= 1'b0;
      o4d_val <= 1'b0;
    end else if (iclkena) begin
      o4d_val <= take && (slot == 2'd3);
      if (take) begin
        cnt <= slot + 2'd1;
        act <= (slot != 2'd3);
      end
    end
  end

  //--------------------------------------------------------------------------
  // slot registers
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && take) begin
      o4d_pnt[slot]         <= ipnt;
      o4d_symb_m[slot]      <= isymb_m;
      o4d_symb_m_sign[slot] <= isymb_m_sign;
      // framing of the 4D symbol comes with its first 8PSK symbol
      if (ival) begin
        o4d_sop <= isop;
        o4d_eop <= ieop;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/tcm_dec_front.sv ====
// 4D-8PSK TCM decoder front end
// symbol metrics, hard decision and 4D packing, 6 enabled cycles from the
// fourth symbol strobe to o4d_val
// pSYMB_M_W must equal tcm_dec_pkg::SYMB_M_W, the metric types use it

`default_nettype none

module tcm_dec_front #(
  parameter int pDAT_W    = tcm_dec_pkg::DAT_W,
  parameter int pSYMB_M_W = tcm_dec_pkg::SYMB_M_W
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  logic                            i1sps,
  input  logic                            isop,
  input  logic                            ival,
  input  logic                            ieop,
  input  logic signed [pDAT_W-1:0]        idat_re,
  input  logic signed [pDAT_W-1:0]        idat_im,
  output logic                            o4d_val,
  output logic                            o4d_sop,
  output logic                            o4d_eop,
  output tcm_dec_pkg::hard_4d_t           o4d_pnt,
  output tcm_dec_pkg::symb_m_t      [3:0] o4d_symb_m,
  output tcm_dec_pkg::symb_m_sign_t [3:0] o4d_symb_m_sign
);

  import tcm_dec_pkg::*;

  //--------------------------------------------------------------------------
  // stage links
  //--------------------------------------------------------------------------

  // metric calculator to hard decision
  logic         mc_1sps;
  logic         mc_sop;
  logic         mc_val;
  logic         mc_eop;
  symb_m_t      mc_symb_m;
  symb_m_sign_t mc_symb_m_sign;

  // hard decision to packer
  logic         hd_1sps;
  logic         hd_sop;
  logic         hd_val;
  logic         hd_eop;
  symb_m_t      hd_symb_m;
  symb_m_sign_t hd_symb_m_sign;
  hard_pnt_t    hd_pnt;

  tcm_dec_symb_mc #(
    .pDAT_W    (pDAT_W),
    .pSYMB_M_W (pSYMB_M_W)
  ) tcm_dec_symb_mc_inst (
    .iclk         (iclk),
    .ireset       (ireset),
    .iclkena      (iclkena),
    .i1sps        (i1sps),
    .isop         (isop),
    .ival         (ival),
    .ieop         (ieop),
    .idat_re      (idat_re),
    .idat_im      (idat_im),
    .o1sps        (mc_1sps),
    .osop         (mc_sop),
    .oval         (mc_val),
    .oeop         (mc_eop),
    .osymb_m      (mc_symb_m),
    .osymb_m_sign (mc_symb_m_sign)
  );

  tcm_dec_hard_dec tcm_dec_hard_dec_inst (
    .iclk         (iclk),
    .ireset       (ireset),
    .iclkena      (iclkena),
    .i1sps        (mc_1sps),
    .isop         (mc_sop),
    .ival         (mc_val),
    .ieop         (mc_eop),
    .isymb_m      (mc_symb_m),
    .isymb_m_sign (mc_symb_m_sign),
    .o1sps        (hd_1sps),
    .osop         (hd_sop),
    .oval         (hd_val),
    .oeop         (hd_eop),
    .osymb_m      (hd_symb_m),
    .osymb_m_sign (hd_symb_m_sign),
    .opnt         (hd_pnt)
  );

  tcm_dec_4d_pack tcm_dec_4d_pack_inst (
    .iclk            (iclk),
    .ireset          (ireset),
    .iclkena         (iclkena),
    .i1sps           (hd_1sps),
    .isop            (hd_sop),
    .ival            (hd_val),
    .ieop            (hd_eop),
    .isymb_m         (hd_symb_m),
    .isymb_m_sign    (hd_symb_m_sign),
    .ipnt            (hd_pnt),
    .o4d_val         (o4d_val),
    .o4d_sop         (o4d_sop),
    .o4d_eop         (o4d_eop),
    .o4d_pnt         (o4d_pnt),
    .o4d_symb_m      (o4d_symb_m),
    .o4d_symb_m_sign (o4d_symb_m_sign)
  );

endmodule

`default_nettype wire

// ==== dv/tcm_dec_front_chk.sv ====
// 4D-8PSK front end checker
// models every 8PSK symbol seen at the DUT inputs, packs the expected
// metrics, signs and points into 4D words and compares on each o4d_val

`default_nettype none

module tcm_dec_front_chk #(
  parameter int pDAT_W    = tcm_dec_pkg::DAT_W,
  parameter int pSYMB_M_W = tcm_dec_pkg::SYMB_M_W
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  logic                            i1sps,
  input  logic                            isop,
  input  logic                            ival,
  input  logic                            ieop,
  input  logic signed [pDAT_W-1:0]        idat_re,
  input  logic signed [pDAT_W-1:0]        idat_im,
  input  logic                            o4d_val,
  input  logic                            o4d_sop,
  input  logic                            o4d_eop,
  input  tcm_dec_pkg::hard_4d_t           o4d_pnt,
  input  tcm_dec_pkg::symb_m_t      [3:0] o4d_symb_m,
  input  tcm_dec_pkg::symb_m_sign_t [3:0] o4d_symb_m_sign,
  output int                              err_cnt,
  output int                              word_cnt,
  output int                              pend_cnt
);

  import tcm_dec_pkg::*;

  // expected 4D words, oldest first
  hard_4d_t           exp_pnt_q  [$];
  symb_m_t      [3:0] exp_m_q    [$];
  symb_m_sign_t [3:0] exp_sign_q [$];
  logic [1:0]         exp_frm_q  [$];

  // group under construction
  hard_4d_t           grp_pnt;
  symb_m_t      [3:0] grp_m;
  symb_m_sign_t [3:0] grp_sign;
  logic [1:0]         grp_frm;
  int                 grp_cnt;
  logic               grp_act;

  //--------------------------------------------------------------------------
  // reference model of one 8PSK symbol
  //--------------------------------------------------------------------------

  function automatic void ref_symbol(input logic signed [pDAT_W-1:0] re,
                                     input logic signed [pDAT_W-1:0] im,
                                     output symb_m_t m, output symb_m_sign_t s,
                                     output hard_pnt_t p);
    int v_re;
    int v_im;
    int c [4];
    int axis;
    int diag;
    int win;
    v_re = re;
    v_im = im;
    // axis metrics, plain magnitudes
    c[0] = (v_re < 0) ? -v_re : v_re;
    c[2] = (v_im < 0) ? -v_im : v_im;
    // diagonal metrics, magnitude times 1/sqrt(2), rounded down
    c[1] = (((v_im + v_re) < 0) ? -(v_im + v_re) : (v_im + v_re));
    c[3] = (((v_im - v_re) < 0) ? -(v_im - v_re) : (v_im - v_re));
    c[1] = (c[1] * SCALE_FACTOR) >> DIV_FACTOR_W;
    c[3] = (c[3] * SCALE_FACTOR) >> DIV_FACTOR_W;
    // ties: im over re, difference over sum, diagonals over axes
    axis = (c[0] > c[2]) ? 0 : 2;
    diag = (c[1] > c[3]) ? 1 : 3;
    win  = (c[axis] > c[diag]) ? axis : diag;
    for (int k = 0; k < 4; k++) begin
      m[k] = pSYMB_M_W'((c[k] >> (pDAT_W - pSYMB_M_W)) + ((k == win) ? 1 : 0));
    end
    s[0] = (v_re < 0);
    s[1] = ((v_im + v_re) < 0);
    s[2] = (v_im < 0);
    s[3] = ((v_im - v_re) < 0);
    // sign set, opposite point
    p = hard_pnt_t'(win + 4 * s[win]);
  endfunction

  //--------------------------------------------------------------------------
  // packing model, val restarts a group at slot 0
  //--------------------------------------------------------------------------

  task automatic model_symbol();
    symb_m_t      m;
    symb_m_sign_t s;
    hard_pnt_t    p;
    int           slot;
    ref_symbol(idat_re, idat_im, m, s, p);
    // symbols outside a group are dropped
    if (ival || grp_act) begin
      slot = ival ? 0 : grp_cnt;
      if (ival) begin
        grp_frm = {isop, ieop};
      end
      grp_pnt[slot]  = p;
      grp_m[slot]    = m;
      grp_sign[slot] = s;
      grp_cnt        = (slot + 1) % 4;
      grp_act        = (slot != 3);
      if (slot == 3) begin
        exp_pnt_q.push_back(grp_pnt);
        exp_m_q.push_back(grp_m);
        exp_sign_q.push_back(grp_sign);
        exp_frm_q.push_back(grp_frm);
      end
    end
  endtask

  task automatic check_field(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %0h expected %0h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic compare_word();
    logic [1:0] frm;
    if (exp_pnt_q.size() == 0) begin
      $display("o4d_val came at %0t without any complete 4D symbol", $time);
      err_cnt++;
    end else begin
      frm = exp_frm_q.pop_front();
      check_field("o4d_sop", o4d_sop, frm[1]);
      check_field("o4d_eop", o4d_eop, frm[0]);
      check_field("o4d_pnt", o4d_pnt, exp_pnt_q.pop_front());
      check_field("o4d_symb_m", o4d_symb_m, exp_m_q.pop_front());
      check_field("o4d_symb_m_sign", o4d_symb_m_sign, exp_sign_q.pop_front());
      word_cnt++;
    end
  endtask

  initial begin
    err_cnt  = 0;
    word_cnt = 0;
    pend_cnt = 0;
    grp_cnt  = 0;
    grp_act  = 1'b0;
  end

  // outputs are read before the edge updates them
  always @(posedge iclk) begin
    if (!ireset && iclkena) begin
      if (o4d_val) begin
        compare_word();
      end
      if (i1sps) begin
        model_symbol();
      end
      pend_cnt = exp_pnt_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== dv/tcm_dec_front_tb.sv ====
// 4D-8PSK front end testbench
// drives clock, reset, LFSR I/Q samples, framing and a random clock enable
// into the DUT while the checker module compares its outputs

`default_nettype none

module tcm_dec_front_tb;

  import tcm_dec_pkg::*;

  logic                    iclk;
  logic                    ireset;
  logic                    iclkena;
  logic                    i1sps;
  logic                    isop;
  logic                    ival;
  logic                    ieop;
  logic signed [DAT_W-1:0] idat_re;
  logic signed [DAT_W-1:0] idat_im;
  logic                    o4d_val;
  logic                    o4d_sop;
  logic                    o4d_eop;
  hard_4d_t                o4d_pnt;
  symb_m_t      [3:0]      o4d_symb_m;
  symb_m_sign_t [3:0]      o4d_symb_m_sign;

  // checker counts
  int err_cnt;
  int word_cnt;
  int pend_cnt;

  logic [31:0] lfsr;
  logic        rand_en;
  int          test_num;
  int          err_base;
  int          word_base;
  int          amp;
  int          dg;
  int          mn;
  int          pt_re [8];
  int          pt_im [8];

  tcm_dec_front #(
    .pDAT_W    (DAT_W),
    .pSYMB_M_W (SYMB_M_W)
  ) tcm_dec_front_inst (
    .iclk            (iclk),
    .ireset          (ireset),
    .iclkena         (iclkena),
    .i1sps           (i1sps),
    .isop            (isop),
    .ival            (ival),
    .ieop            (ieop),
    .idat_re         (idat_re),
    .idat_im         (idat_im),
    .o4d_val         (o4d_val),
    .o4d_sop         (o4d_sop),
    .o4d_eop         (o4d_eop),
    .o4d_pnt         (o4d_pnt),
    .o4d_symb_m      (o4d_symb_m),
    .o4d_symb_m_sign (o4d_symb_m_sign)
  );

  tcm_dec_front_chk #(
    .pDAT_W    (DAT_W),
    .pSYMB_M_W (SYMB_M_W)
  ) chk_inst (
    .iclk            (iclk),
    .ireset          (ireset),
    .iclkena         (iclkena),
    .i1sps           (i1sps),
    .isop            (isop),
    .ival            (ival),
    .ieop            (ieop),
    .idat_re         (idat_re),
    .idat_im         (idat_im),
    .o4d_val         (o4d_val),
    .o4d_sop         (o4d_sop),
    .o4d_eop         (o4d_eop),
    .o4d_pnt         (o4d_pnt),
    .o4d_symb_m      (o4d_symb_m),
    .o4d_symb_m_sign (o4d_symb_m_sign),
    .err_cnt         (err_cnt),
    .word_cnt        (word_cnt),
    .pend_cnt        (pend_cnt)
  );

  initial begin
    iclk = 1'b0;
    forever #50 iclk = ~iclk;
  end

  //--------------------------------------------------------------------------
  // random source
  //--------------------------------------------------------------------------

  // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  //--------------------------------------------------------------------------
  // clocking and symbol drive
  //--------------------------------------------------------------------------

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Result: FAILED");
    $finish;
  endtask

  // one clock with inputs changing 10 after the edge
  task automatic clock_cycle(output logic en);
    en = iclkena;
    @(posedge iclk);
    #10;
    // enable about three cycles in four
    iclkena = rand_en ? (rand_bits(2) != 0) : 1'b1;
  endtask

  task automatic enabled_cycles(input int n);
    logic en;
    int   seen;
    int   waited;
    seen   = 0;
    waited = 0;
    while (seen < n) begin
      clock_cycle(en);
      if (en) begin
        seen++;
      end
      waited++;
      if (waited > 100 * n) begin
        fail_timeout("enabled clock cycles");
      end
    end
  endtask

  task automatic send_symbol(input int re, input int im, input logic v,
                             input logic sp, input logic ep);
    idat_re = DAT_W'(re);
    idat_im = DAT_W'(im);
    ival    = v;
    isop    = sp;
    ieop    = ep;
    i1sps   = 1'b1;
    enabled_cycles(1);
    i1sps = 1'b0;
    ival  = 1'b0;
    isop  = 1'b0;
    ieop  = 1'b0;
    // metric stage takes four enabled cycles per symbol
    enabled_cycles(3);
  endtask

  task automatic send_random(input logic v, input logic sp, input logic ep);
    logic signed [DAT_W-1:0] re;
    logic signed [DAT_W-1:0] im;
    re = DAT_W'(rand_bits(DAT_W));
    im = DAT_W'(rand_bits(DAT_W));
    send_symbol(re, im, v, sp, ep);
  endtask

  task automatic send_group(input logic sp, input logic ep);
    send_random(1'b1, sp, ep);
    repeat (3) send_random(1'b0, 1'b0, 1'b0);
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (pend_cnt != 0) begin
      enabled_cycles(1);
      waited++;
      if (waited > 64) begin
        fail_timeout({"4D symbols of test ", name});
      end
    end
    // room for a stray o4d_val
    enabled_cycles(8);
    test_num++;
    $display("test %0d %s: %0d 4D symbols, %0d errors", test_num, name,
             word_cnt - word_base, err_cnt - err_base);
    err_base  = err_cnt;
    word_base = word_cnt;
  endtask

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------

  initial begin
    ireset    = 1'b1;
    iclkena   = 1'b1;
    i1sps     = 1'b0;
    isop      = 1'b0;
    ival      = 1'b0;
    ieop      = 1'b0;
    idat_re   = '0;
    idat_im   = '0;
    rand_en   = 1'b0;
    lfsr      = 32'h2555_3053;
    test_num  = 0;
    err_base  = 0;
    word_base = 0;
    repeat (16) @(posedge iclk);
    #10;
    ireset = 1'b0;

    // reset, loose symbols and an unfinished group give no output
    enabled_cycles(20);
    repeat (3) send_random(1'b0, 1'b0, 1'b0);
    send_random(1'b1, 1'b0, 1'b0);
    repeat (2) send_random(1'b0, 1'b0, 1'b0);
    enabled_cycles(12);
    finish_test("reset");

    // ideal points at full amplitude counter clockwise from C0
    amp = (1 << (DAT_W - 1)) - 1;
    dg  = (amp * 181 + 128) >> 8;
    pt_re = '{amp, dg, 0, -dg, -amp, -dg, 0, dg};
    pt_im = '{0, dg, amp, dg, 0, -dg, -amp, -dg};
    for (int k = 0; k < 8; k++) begin
      send_symbol(pt_re[k], pt_im[k], (k % 4) == 0, 1'b0, 1'b0);
    end
    finish_test("ideal points");

    // random samples with the most negative value first
    mn = -(1 << (DAT_W - 1));
    send_symbol(mn, mn, 1'b1, 1'b0, 1'b0);
    send_symbol(mn, amp, 1'b0, 1'b0, 1'b0);
    send_symbol(amp, mn, 1'b0, 1'b0, 1'b0);
    send_symbol(mn, 0, 1'b0, 1'b0, 1'b0);
    repeat (24) send_group(1'b0, 1'b0);
    finish_test("random samples");

    rand_en = 1'b1;
    repeat (24) send_group(1'b0, 1'b0);
    finish_test("random clock enable");

    // frames of 1 to 4 groups and then a val in the middle of a group
    for (int f = 1; f <= 4; f++) begin
      for (int g = 0; g < f; g++) begin
        send_group(g == 0, g == f - 1);
      end
      send_random(1'b0, 1'b0, 1'b0);
    end
    send_random(1'b1, 1'b1, 1'b0);
    repeat (2) send_random(1'b0, 1'b0, 1'b0);
    send_group(1'b0, 1'b1);
    finish_test("framing");

    $display("tests %0d, 4D symbols %0d, errors %0d", test_num, word_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/tcm_dec_pkg.sv
design/tcm_dec_symb_mc.sv
design/tcm_dec_hard_dec.sv
design/tcm_dec_4d_pack.sv
design/tcm_dec_front.sv
dv/tcm_dec_front_chk.sv
dv/tcm_dec_front_tb.sv
